// ==== src/bf_consts.svh ====
`ifndef BF_CONSTS_SVH
`define BF_CONSTS_SVH

// lane count and sample widths at the ports.
`define BF_LANES    32
`define BF_IN_W     27
`define BF_OUT_W    28

// input width of each column; its output is one bit wider.
`define BF_W8       25
`define BF_W16      26
`define BF_W32      27

// butterfly group size of each column.
`define BF_N8       8
`define BF_N16      16
`define BF_N32      32

// transform size codes on i_size.
`define BF_SIZE_4   2'd0
`define BF_SIZE_8   2'd1
`define BF_SIZE_16  2'd2
`define BF_SIZE_32  2'd3

`endif

// ==== src/bf_pkg.sv ====
`include "bf_consts.svh"

package bf_pkg;

    function automatic int size_points(input logic [1:0] size);
        case (size)
            `BF_SIZE_4:  return 4;
            `BF_SIZE_8:  return 8;
            `BF_SIZE_16: return 16;
            default:     return 32;
        endcase
    endfunction

    // a group of n lanes is active when the transform spans it and g sits on
    // the start of a transform block.
    function automatic logic group_enabled(input logic [1:0] size, input int n, input int g);
        int s;
        s = size_points(size);
        if (s < n)
        begin
            return 1'b0; // transform smaller than the group.
        end
        return (g % (s / n)) == 0;
    endfunction

    function automatic int col_in_w(input int n);
        case (n)
            `BF_N8:  return `BF_W8;
            `BF_N16: return `BF_W16;
            default: return `BF_W32;
        endcase
    endfunction

    function automatic int col_out_w(input int n);
        return col_in_w(n) + 1; // one bit of growth per column.
    endfunction

endpackage

// ==== src/bf_lanes_if.sv ====
`include "bf_consts.svh"

interface bf_lanes_if #(
    parameter int W = `BF_W8
);

    logic signed [W-1:0] lanes [`BF_LANES];

    modport src (
        output lanes
    );

    modport dst (
        input lanes
    );

endinterface

// ==== src/bf_column.sv ====
`include "bf_consts.svh"

module bf_column
    import bf_pkg::*;
#(
    parameter int N = `BF_N8,
    parameter int W = `BF_W8
)
(
    input  logic [1:0]     i_size,
    bf_lanes_if.dst        lanes_in,
    bf_lanes_if.src        lanes_out
);

    localparam int NG = `BF_LANES / N; // groups in this column.
    localparam int NH = N / 2;

    for (genvar g = 0; g < NG; g++)
    begin : g_grp
        logic en;

        assign en = group_enabled(i_size, N, g);

        // pair k with its mirror N-1-k inside the group.
        for (genvar k = 0; k < NH; k++)
        begin : g_pair
            localparam int LO = g * N + k;
            localparam int HI = g * N + N - 1 - k;

            logic signed [W:0] a;
            logic signed [W:0] b;
            logic signed [W:0] sum;
            logic signed [W:0] dif;

            assign a   = lanes_in.lanes[LO]; // sign-extended.
            assign b   = lanes_in.lanes[HI];
            assign sum = a + b;
            assign dif = a - b;

            assign lanes_out.lanes[LO] = en ? sum : a;
            assign lanes_out.lanes[HI] = en ? dif : b; // bypass when idle.
        end
    end

endmodule

// ==== src/bf_order_route.sv ====
`include "bf_consts.svh"

module bf_order_route
    import bf_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_valid,
    input  logic                        i_inverse,
    input  logic signed [`BF_IN_W-1:0]  i_data [`BF_LANES],
    bf_lanes_if.src                     col8_in,
    bf_lanes_if.src                     col16_in,
    bf_lanes_if.src                     col32_in,
    bf_lanes_if.dst                     col8_out,
    bf_lanes_if.dst                     col16_out,
    bf_lanes_if.dst                     col32_out,
    output logic                        o_valid,
    output logic signed [`BF_OUT_W-1:0] o_data [`BF_LANES]
);

    localparam int W8  = col_in_w(`BF_N8);
    localparam int W16 = col_in_w(`BF_N16);
    localparam int O8  = col_out_w(`BF_N8);

    logic signed [`BF_OUT_W-1:0] result [`BF_LANES];

    // forward is 32 -> 16 -> 8, inverse is 8 -> 16 -> 32.
    for (genvar i = 0; i < `BF_LANES; i++)
    begin : g_lane
        logic signed [W8-1:0]       in_lo;
        logic signed [W8-1:0]       c16_lo;
        logic signed [W16-1:0]      c32_lo;
        logic signed [`BF_OUT_W-1:0] fwd;

        // keep the low bits only, wider values wrap.
        assign in_lo  = $signed(i_data[i][W8-1:0]);
        assign c16_lo = $signed(col16_out.lanes[i][W8-1:0]);
        assign c32_lo = $signed(col32_out.lanes[i][W16-1:0]);

        assign col32_in.lanes[i] = i_inverse ? col16_out.lanes[i] : i_data[i];
        assign col16_in.lanes[i] = i_inverse ? col8_out.lanes[i] : c32_lo;
        assign col8_in.lanes[i]  = i_inverse ? in_lo : c16_lo;

        assign fwd = {{(`BF_OUT_W - O8){col8_out.lanes[i][O8-1]}}, col8_out.lanes[i]};

        assign result[i] = i_inverse ? col32_out.lanes[i] : fwd;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid; // one cycle behind the input strobe.
        end
    end

    // loads every cycle, meaningful only under o_valid.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < `BF_LANES; i++)
            begin
                o_data[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < `BF_LANES; i++)
            begin
                o_data[i] <= result[i];
            end
        end
    end

endmodule

// ==== src/bf_network.sv ====
`include "bf_consts.svh"

module bf_network (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_valid,
    input  logic                        i_inverse,
    input  logic [1:0]                  i_size,
    input  logic signed [`BF_IN_W-1:0]  i_data [`BF_LANES],
    output logic                        o_valid,
    output logic signed [`BF_OUT_W-1:0] o_data [`BF_LANES]
);

    // lane buses around the three columns.
    bf_lanes_if #(.W(`BF_W8))      col8_in ();
    bf_lanes_if #(.W(`BF_W8 + 1))  col8_out ();
    bf_lanes_if #(.W(`BF_W16))     col16_in ();
    bf_lanes_if #(.W(`BF_W16 + 1)) col16_out ();
    bf_lanes_if #(.W(`BF_W32))     col32_in ();
    bf_lanes_if #(.W(`BF_W32 + 1)) col32_out ();

    bf_column #(
        .N (`BF_N8),
        .W (`BF_W8)
    ) col8 (
        .i_size    (i_size),
        .lanes_in  (col8_in),
        .lanes_out (col8_out)
    );

    bf_column #(
        .N (`BF_N16),
        .W (`BF_W16)
    ) col16 (
        .i_size    (i_size),
        .lanes_in  (col16_in),
        .lanes_out (col16_out)
    );

    bf_column #(
        .N (`BF_N32),
        .W (`BF_W32)
    ) col32 (
        .i_size    (i_size),
        .lanes_in  (col32_in),
        .lanes_out (col32_out)
    );

    // column order, truncation and the output register.
    bf_order_route route (
        .clk       (clk),
        .rst       (rst),
        .i_valid   (i_valid),
        .i_inverse (i_inverse),
        .i_data    (i_data),
        .col8_in   (col8_in),
        .col16_in  (col16_in),
        .col32_in  (col32_in),
        .col8_out  (col8_out),
        .col16_out (col16_out),
        .col32_out (col32_out),
        .o_valid   (o_valid),
        .o_data    (o_data)
    );

endmodule

// ==== verification/bf_properties.sv ====
`include "bf_consts.svh"

module bf_properties (
    input logic                        clk,
    input logic                        rst,
    input logic                        i_valid,
    input logic                        o_valid,
    input logic signed [`BF_OUT_W-1:0] o_data [`BF_LANES]
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`BF_LANES*`BF_OUT_W-1:0] o_flat;

    always_comb
    begin
        for (int i = 0; i < `BF_LANES; i++)
        begin
            o_flat[i*`BF_OUT_W +: `BF_OUT_W] = o_data[i];
        end
    end

    reset_quiet: assert property (@(posedge clk) !rst |-> !o_valid)
        else $error("o_valid is high while reset is asserted");

    // the strobe trails the input by exactly one edge.
    valid_delay: assert property (@(posedge clk) disable iff (!rst)
        $past(rst) |-> o_valid == $past(i_valid))
        else $error("o_valid does not follow i_valid of the previous cycle");

    data_known: assert property (@(posedge clk) disable iff (!rst)
        o_valid |-> !$isunknown(o_flat))
        else $error("o_data has unknown bits while o_valid is high");

endmodule

bind bf_network bf_properties bf_properties_inst (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .o_valid (o_valid),
    .o_data  (o_data)
);

// ==== verification/tb_bf_network.sv ====
`include "bf_consts.svh"

module tb_bf_network;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 5;
    localparam int N_RAND      = 6;  // random words per size and direction.
    localparam int N_MIX       = 40;
    localparam int N_FULL      = 4;
    localparam int TEST_CYCLES = RST_CYCLES + 1 + 2 * N_RAND + 6 * N_RAND + N_MIX + 3 * N_FULL;
    localparam int TIMEOUT     = (TEST_CYCLES + 20) * CLK_PERIOD;

    typedef longint lane_vec_t [`BF_LANES];

    logic                        clk;
    logic                        rst;
    logic                        i_valid;
    logic                        i_inverse;
    logic [1:0]                  i_size;
    logic signed [`BF_IN_W-1:0]  i_data [`BF_LANES];
    logic                        o_valid;
    logic signed [`BF_OUT_W-1:0] o_data [`BF_LANES];

    int        seed;
    int        checks;
    int        errors;
    lane_vec_t stim;

    bf_network bf_network_inst (
        .clk       (clk),
        .rst       (rst),
        .i_valid   (i_valid),
        .i_inverse (i_inverse),
        .i_size    (i_size),
        .i_data    (i_data),
        .o_valid   (o_valid),
        .o_data    (o_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // low w bits of v, read back as a signed value.
    function automatic longint wrap(input longint v, input int w);
        longint m;
        m = v & ((longint'(1) << w) - 1);
        if (m[w-1])
        begin
            m = m - (longint'(1) << w);
        end
        return m;
    endfunction

    function automatic int points(input logic [1:0] size);
        return 4 << size;  // code 0 is 4 points, each step doubles.
    endfunction

    // one column truncates to w bits and butterflies the groups that the size covers.
    task automatic model_column(input lane_vec_t din, input int n, input int w,
                                input logic [1:0] size, output lane_vec_t dout);
        int     s;
        bit     active;
        longint a;
        longint b;
        s = points(size);
        for (int g = 0; g < `BF_LANES / n; g++)
        begin
            active = (s >= n) && ((g * n) % s == 0);  // group starts a transform block.
            for (int k = 0; k < n / 2; k++)
            begin
                a = wrap(din[g * n + k], w);
                b = wrap(din[g * n + n - 1 - k], w);
                dout[g * n + k]         = active ? a + b : a;
                dout[g * n + n - 1 - k] = active ? a - b : b;
            end
        end
    endtask

    task automatic model_word(input lane_vec_t din, input logic inv, input logic [1:0] size,
                              output lane_vec_t dout);
        lane_vec_t c8;
        lane_vec_t c16;
        lane_vec_t c32;
        if (inv)
        begin
            model_column(din, 8, `BF_W8, size, c8);
            model_column(c8, 16, `BF_W16, size, c16);
            model_column(c16, 32, `BF_W32, size, dout);
        end
        else
        begin
            model_column(din, 32, `BF_W32, size, c32);
            model_column(c32, 16, `BF_W16, size, c16);
            model_column(c16, 8, `BF_W8, size, dout);
        end
    endtask

    task automatic fill_random(input int w);
        for (int i = 0; i < `BF_LANES; i++)
        begin
            stim[i] = wrap(longint'($random(seed)), w);
        end
    endtask

    // lanes a few steps away from the 27-bit limits.
    task automatic fill_full_scale();
        int r;
        for (int i = 0; i < `BF_LANES; i++)
        begin
            r = $random(seed) & 255;
            if ($random(seed) & 1)
            begin
                stim[i] = (longint'(1) << (`BF_IN_W - 1)) - 1 - r;
            end
            else
            begin
                stim[i] = r - (longint'(1) << (`BF_IN_W - 1));
            end
        end
    endtask

    // called at a falling edge, returns at the falling edge one cycle later.
    task automatic run_word(input logic v, input logic inv, input logic [1:0] size);
        lane_vec_t want;
        model_word(stim, inv, size, want);
        i_valid   = v;
        i_inverse = inv;
        i_size    = size;
        for (int i = 0; i < `BF_LANES; i++)
        begin
            i_data[i] = stim[i][`BF_IN_W-1:0];
        end
        @(posedge clk);
        @(negedge clk);
        checks++;
        assert (o_valid == v)
        else
        begin
            errors++;
            $display("mismatch at %0t: o_valid is %0b, expected %0b", $time, o_valid, v);
        end
        if (v)
        begin
            for (int i = 0; i < `BF_LANES; i++)
            begin
                checks++;
                assert (longint'(o_data[i]) == want[i])
                else
                begin
                    errors++;
                    $display("mismatch at %0t: lane %0d is %0d, expected %0d",
                             $time, i, o_data[i], want[i]);
                end
            end
        end
    endtask

    task automatic check_reset();
        checks++;
        assert (o_valid == 1'b0)
        else
        begin
            errors++;
            $display("mismatch at %0t: o_valid is %0b after reset", $time, o_valid);
        end
        for (int i = 0; i < `BF_LANES; i++)
        begin
            checks++;
            assert (o_data[i] == '0)
            else
            begin
                errors++;
                $display("mismatch at %0t: lane %0d is %0d after reset", $time, i, o_data[i]);
            end
        end
    endtask

    task automatic test_size4();
        for (int d = 0; d < 2; d++)
        begin
            for (int n = 0; n < N_RAND; n++)
            begin
                fill_random(`BF_W8);  // fits the narrowest column.
                run_word(1'b1, d[0], `BF_SIZE_4);
            end
        end
    endtask

    task automatic test_direction(input logic inv);
        for (int s = 1; s < 4; s++)
        begin
            for (int n = 0; n < N_RAND; n++)
            begin
                fill_random(`BF_IN_W);
                run_word(1'b1, inv, s[1:0]);
            end
        end
    endtask

    task automatic test_mixed();
        logic v;
        for (int n = 0; n < N_MIX; n++)
        begin
            v = ($random(seed) & 3) != 0;  // roughly one gap in four.
            fill_random(`BF_IN_W);
            run_word(v, 1'($random(seed)), 2'($random(seed)));
        end
    endtask

    task automatic test_full_scale();
        for (int d = 0; d < 2; d++)
        begin
            for (int s = 1; s < 4; s++)
            begin
                for (int n = 0; n < N_FULL / 2; n++)
                begin
                    fill_full_scale();
                    run_word(1'b1, d[0], s[1:0]);
                end
            end
        end
    endtask

    initial
    begin
        seed      = 32'h8439dd3e;
        checks    = 0;
        errors    = 0;
        rst       = 1'b0;
        i_valid   = 1'b0;
        i_inverse = 1'b0;
        i_size    = `BF_SIZE_4;
        for (int i = 0; i < `BF_LANES; i++)
        begin
            i_data[i] = '0;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b1;
        check_reset();
        test_size4();
        test_direction(1'b0);
        test_direction(1'b1);
        test_mixed();
        test_full_scale();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
src/bf_pkg.sv
src/bf_lanes_if.sv
src/bf_column.sv
src/bf_order_route.sv
src/bf_network.sv
verification/bf_properties.sv
verification/tb_bf_network.sv

// ==== Makefile ====
# Verilator simulation of the butterfly network testbench.

TOP       ?= tb_bf_network
FLIST     ?= flist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
